// File: rtl/sprite_params.svh
// sprite geometry and arbiter size
`ifndef SPRITE_PARAMS_SVH
`define SPRITE_PARAMS_SVH

// box edge in pixels
`define SPRITE_SIDE 8

// box extends this far left/up of the position
`define SPRITE_HALF 4

// 4 poses x 64 pixels
`define ROM_DEPTH 256

// 0 = sprite 0, 1 = sprite 1, 2 = loader
`define NUM_REQ 3

`endif

// File: rtl/sprite_pkg.sv
// sprite layer shared types
`default_nettype none

package sprite_pkg;

    // ------------------------------------------------------------------------
    // pixel stream and palette
    // ------------------------------------------------------------------------

    // screen coordinate, unsigned
    typedef logic [9:0] coord_t;

    // palette index, 0 is see-through
    typedef logic [3:0] color_t;

    // ------------------------------------------------------------------------
    // image memory
    // ------------------------------------------------------------------------

    // four image blocks of 64 pixels each
    typedef enum logic [1:0] {
        pose_stand,
        pose_move_right,
        pose_move_left,
        pose_attack
    } pose_t;

    // {pose, row, col} -> pose*64 + row*8 + col
    typedef logic [7:0] rom_addr_t;

endpackage

`default_nettype wire

// File: rtl/sprite_unit.sv
// per-sprite box test and image fetch
`default_nettype none
`include "sprite_params.svh"

module sprite_unit
    import sprite_pkg::*;
(
    input  logic      Clk,
    input  logic      rst_n,
    input  logic      start,
    input  coord_t    pix_x,
    input  coord_t    pix_y,
    input  coord_t    pos_x,
    input  coord_t    pos_y,
    input  pose_t     pose,
    output logic      req,
    output rom_addr_t addr,
    input  logic      gnt,
    input  color_t    rd_data,
    output logic      done,
    output logic      hit,
    output color_t    color
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_capture
    } state_t;

    state_t state;

    // offsets into the image, signed so the box edge never wraps
    // 12 bits covers 1023 + half box
    logic signed [11:0] off_x;
    logic signed [11:0] off_y;
    logic               in_box;
    rom_addr_t          img_addr;

    rom_addr_t addr_q;
    logic      hit_q;
    logic      miss_done;

    // ------------------------------------------------------------------------
    // box test
    // ------------------------------------------------------------------------

    // column = x - px + 4, row = y - py + 4
    assign off_x = $signed({2'b00, pix_x}) - $signed({2'b00, pos_x}) + 12'sd`SPRITE_HALF;
    assign off_y = $signed({2'b00, pix_y}) - $signed({2'b00, pos_y}) + 12'sd`SPRITE_HALF;

    assign in_box = (off_x >= 0) && (off_x < `SPRITE_SIDE) &&
                    (off_y >= 0) && (off_y < `SPRITE_SIDE);

    // pose selects the 64-entry block
    assign img_addr = {pose, off_y[2:0], off_x[2:0]};

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            hit_q     <= 1'b0;
            miss_done <= 1'b0;
        end else begin
            // miss answer is a one-cycle pulse
            miss_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        hit_q <= in_box;
                        if (in_box) begin
                            state <= st_request;
                        end else begin
                            miss_done <= 1'b1;
                        end
                    end
                end
                st_request: begin
                    // memory samples the address on this edge
                    if (gnt) begin
                        state <= st_capture;
                    end
                end
                st_capture: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // address held while waiting for the grant
    always_ff @(posedge Clk) begin
        if (state == st_idle && start) begin
            addr_q <= img_addr;
        end
    end

    assign req  = (state == st_request);
    assign addr = addr_q;
    assign hit  = hit_q;

    // registered read data lands in capture, one cycle after grant
    assign done  = miss_done | (state == st_capture);
    assign color = (state == st_capture) ? rd_data : '0;

endmodule

`default_nettype wire

// File: rtl/rom_arbiter.sv
// round-robin arbiter for the image memory port
`default_nettype none
`include "sprite_params.svh"

module rom_arbiter
    import sprite_pkg::*;
(
    input  logic                Clk,
    input  logic                rst_n,
    input  logic [`NUM_REQ-1:0] req,
    input  rom_addr_t           req_addr0,
    input  rom_addr_t           req_addr1,
    input  rom_addr_t           req_addr2,
    input  color_t              wr_data,
    output logic [`NUM_REQ-1:0] gnt,
    output rom_addr_t           mem_addr,
    output logic                mem_we,
    output color_t              mem_wdata
);

    localparam int PTR_W = $clog2(`NUM_REQ);

    // requester with top priority this cycle
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] win;

    // scan from ptr, first asking requester wins
    always_comb begin
        int   cand;
        logic found;
        gnt   = '0;
        win   = ptr;
        found = 1'b0;
        for (int i = 0; i < `NUM_REQ; i++) begin
            cand = int'(ptr) + i;
            if (cand >= `NUM_REQ) begin
                cand = cand - `NUM_REQ;
            end
            if (!found && req[cand]) begin
                found     = 1'b1;
                win       = PTR_W'(cand);
                gnt[cand] = 1'b1;
            end
        end
    end

    // rotate to the one after the last winner
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (|gnt) begin
            ptr <= (win == PTR_W'(`NUM_REQ - 1)) ? '0 : win + 1'b1;
        end
    end

    // route the granted address
    always_comb begin
        mem_addr = req_addr0;
        if (gnt[1]) begin
            mem_addr = req_addr1;
        end
        if (gnt[2]) begin
            mem_addr = req_addr2;
        end
    end

    // only the loader writes
    assign mem_we    = gnt[2];
    assign mem_wdata = wr_data;

endmodule

`default_nettype wire

// File: rtl/sprite_rom.sv
// pose image memory
`default_nettype none
`include "sprite_params.svh"

module sprite_rom
    import sprite_pkg::*;
(
    input  logic      Clk,
    input  rom_addr_t addr,
    input  logic      we,
    input  color_t    wdata,
    output color_t    rdata
);

    // 4 bits per pixel, block RAM style
    color_t mem [`ROM_DEPTH];

    // ------------------------------------------------------------------------
    // single port, one access per edge
    // ------------------------------------------------------------------------

    always_ff @(posedge Clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read data valid the cycle after the address
    // old data on a same-address write
    always_ff @(posedge Clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: rtl/pixel_compositor.sv
// pixel accept, sprite merge and output hold
`default_nettype none

module pixel_compositor
    import sprite_pkg::*;
(
    input  logic   Clk,
    input  logic   rst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  coord_t in_x,
    input  coord_t in_y,
    output logic   start,
    output coord_t pix_x,
    output coord_t pix_y,
    input  logic   done0,
    input  logic   hit0,
    input  color_t color0,
    input  logic   done1,
    input  logic   hit1,
    input  color_t color1,
    output logic   out_valid,
    input  logic   out_ready,
    output color_t out_color,
    output logic   out_opaque
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_present
    } state_t;

    state_t state;

    // sticky done, units finish in either order
    logic   flag0;
    logic   flag1;
    logic   hit0_q;
    logic   hit1_q;
    color_t color0_q;
    color_t color1_q;

    // current-or-held unit results
    logic   h0;
    logic   h1;
    color_t c0;
    color_t c1;
    logic   both_done;
    color_t pick_color;
    logic   pick_opaque;

    // ------------------------------------------------------------------------
    // merge
    // ------------------------------------------------------------------------

    assign h0 = done0 ? hit0 : hit0_q;
    assign c0 = done0 ? color0 : color0_q;
    assign h1 = done1 ? hit1 : hit1_q;
    assign c1 = done1 ? color1 : color1_q;

    // last done can arrive this very cycle
    assign both_done = (flag0 | done0) & (flag1 | done1);

    // sprite 0 in front, color 0 falls through
    always_comb begin
        pick_color  = '0;
        pick_opaque = 1'b0;
        if (h0 && c0 != '0) begin
            pick_color  = c0;
            pick_opaque = 1'b1;
        end else if (h1 && c1 != '0) begin
            pick_color  = c1;
            pick_opaque = 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state <= st_idle;
            start <= 1'b0;
            flag0 <= 1'b0;
            flag1 <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        state <= st_busy;
                        start <= 1'b1;
                        flag0 <= 1'b0;
                        flag1 <= 1'b0;
                    end
                end
                st_busy: begin
                    if (done0) begin
                        flag0 <= 1'b1;
                    end
                    if (done1) begin
                        flag1 <= 1'b1;
                    end
                    if (both_done) begin
                        state <= st_present;
                    end
                end
                st_present: begin
                    // in_ready back the cycle after the output transfer
                    if (out_ready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge Clk) begin
        if (state == st_idle && in_valid) begin
            pix_x <= in_x;
            pix_y <= in_y;
        end
        if (done0) begin
            hit0_q   <= hit0;
            color0_q <= color0;
        end
        if (done1) begin
            hit1_q   <= hit1;
            color1_q <= color1;
        end
        // result frozen while presented
        if (state == st_busy && both_done) begin
            out_color  <= pick_color;
            out_opaque <= pick_opaque;
        end
    end

    assign in_ready  = (state == st_idle);
    assign out_valid = (state == st_present);

endmodule

`default_nettype wire

// File: rtl/sprite_layer_top.sv
// sprite layer top level
`default_nettype none

module sprite_layer_top
    import sprite_pkg::*;
(
    input  logic      Clk,
    input  logic      rst_n,
    // pixel in
    input  logic      in_valid,
    output logic      in_ready,
    input  coord_t    in_x,
    input  coord_t    in_y,
    // pixel out
    output logic      out_valid,
    input  logic      out_ready,
    output color_t    out_color,
    output logic      out_opaque,
    // sprite placement
    input  coord_t    s0_x,
    input  coord_t    s0_y,
    input  pose_t     s0_pose,
    input  coord_t    s1_x,
    input  coord_t    s1_y,
    input  pose_t     s1_pose,
    // image loader
    input  logic      wr_valid,
    output logic      wr_ready,
    input  rom_addr_t wr_addr,
    input  color_t    wr_data
);

    logic      start;
    coord_t    pix_x;
    coord_t    pix_y;
    logic      done0;
    logic      hit0;
    color_t    color0;
    logic      done1;
    logic      hit1;
    color_t    color1;
    logic      req0;
    logic      req1;
    logic      gnt0;
    logic      gnt1;
    rom_addr_t addr0;
    rom_addr_t addr1;
    rom_addr_t mem_addr;
    logic      mem_we;
    color_t    mem_wdata;
    color_t    mem_rdata;

    pixel_compositor u_compositor (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_x       (in_x),
        .in_y       (in_y),
        .start      (start),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .done0      (done0),
        .hit0       (hit0),
        .color0     (color0),
        .done1      (done1),
        .hit1       (hit1),
        .color1     (color1),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_color  (out_color),
        .out_opaque (out_opaque)
    );

    // ------------------------------------------------------------------------
    // sprite units, both read the shared memory output
    // ------------------------------------------------------------------------

    sprite_unit u_sprite0 (
        .Clk     (Clk),
        .rst_n   (rst_n),
        .start   (start),
        .pix_x   (pix_x),
        .pix_y   (pix_y),
        .pos_x   (s0_x),
        .pos_y   (s0_y),
        .pose    (s0_pose),
        .req     (req0),
        .addr    (addr0),
        .gnt     (gnt0),
        .rd_data (mem_rdata),
        .done    (done0),
        .hit     (hit0),
        .color   (color0)
    );

    sprite_unit u_sprite1 (
        .Clk     (Clk),
        .rst_n   (rst_n),
        .start   (start),
        .pix_x   (pix_x),
        .pix_y   (pix_y),
        .pos_x   (s1_x),
        .pos_y   (s1_y),
        .pose    (s1_pose),
        .req     (req1),
        .addr    (addr1),
        .gnt     (gnt1),
        .rd_data (mem_rdata),
        .done    (done1),
        .hit     (hit1),
        .color   (color1)
    );

    // ------------------------------------------------------------------------
    // memory port
    // ------------------------------------------------------------------------

    // loader asks with wr_valid, its grant is wr_ready
    rom_arbiter u_arbiter (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .req       ({wr_valid, req1, req0}),
        .req_addr0 (addr0),
        .req_addr1 (addr1),
        .req_addr2 (wr_addr),
        .wr_data   (wr_data),
        .gnt       ({wr_ready, gnt1, gnt0}),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata)
    );

    sprite_rom u_rom (
        .Clk   (Clk),
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: verification/clk_gen.sv
// testbench clock and reset
`default_nettype none

module clk_gen (
    output logic Clk,
    output logic rst_n
);

    // period 8
    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // reset held over 4 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/sprite_sva.sv
// handshake and grant assertions
`default_nettype none
`include "sprite_params.svh"

module sprite_sva
    import sprite_pkg::*;
(
    input logic                Clk,
    input logic                rst_n,
    input logic                out_valid,
    input logic                out_ready,
    input color_t              out_color,
    input logic                out_opaque,
    input logic [`NUM_REQ-1:0] gnt,
    input logic [`NUM_REQ-1:0] req
);

    // set once reset has been seen on a previous edge
    logic rst_held;

    always_ff @(posedge Clk) begin
        rst_held <= !rst_n;
    end

    // ------------------------------------------------------------------------
    // output channel
    // ------------------------------------------------------------------------

    // stalled result keeps valid and payload
    a_out_hold: assert property (@(posedge Clk) disable iff (!rst_n)
        out_valid && !out_ready |=>
            out_valid && $stable(out_color) && $stable(out_opaque))
    else $error("output payload changed while stalled");

    // ------------------------------------------------------------------------
    // memory port grants
    // ------------------------------------------------------------------------

    // one winner at most, and only one that asked
    a_gnt_legal: assert property (@(posedge Clk) disable iff (!rst_n)
        $onehot0(gnt) && ((gnt & ~req) == '0))
    else $error("illegal grant vector");

    // loader grant is gnt[2], so wr_ready is covered here too
    a_quiet_in_reset: assert property (@(posedge Clk)
        (!rst_n && rst_held) |-> (gnt == '0) && !out_valid)
    else $error("grant or output valid high during reset");

endmodule

// compositor side, no grants there
bind pixel_compositor sprite_sva u_sva_comp (
    .Clk        (Clk),
    .rst_n      (rst_n),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_color  (out_color),
    .out_opaque (out_opaque),
    .gnt        ('0),
    .req        ('0)
);

// arbiter side, output channel idle
bind rom_arbiter sprite_sva u_sva_arb (
    .Clk        (Clk),
    .rst_n      (rst_n),
    .out_valid  (1'b0),
    .out_ready  (1'b1),
    .out_color  ('0),
    .out_opaque (1'b0),
    .gnt        (gnt),
    .req        (req)
);

`default_nettype wire

// File: verification/sprite_tb.sv
// sprite layer directed testbench
`default_nettype none
`include "sprite_params.svh"

module sprite_tb
    import sprite_pkg::*;
();

    // longest wait for any one handshake
    localparam int HS_LIMIT = 50;
    // upper bounds on what the tests issue
    localparam int PIXEL_BUDGET = 40;
    localparam int WRITE_BUDGET = 272;
    localparam int WATCHDOG_CYCLES = 200 * (PIXEL_BUDGET + WRITE_BUDGET);

    logic      Clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    coord_t    in_x;
    coord_t    in_y;
    logic      out_valid;
    logic      out_ready;
    color_t    out_color;
    logic      out_opaque;
    coord_t    s0_x;
    coord_t    s0_y;
    pose_t     s0_pose;
    coord_t    s1_x;
    coord_t    s1_y;
    pose_t     s1_pose;
    logic      wr_valid;
    logic      wr_ready;
    rom_addr_t wr_addr;
    color_t    wr_data;

    // mirror of every loader write
    color_t image [`ROM_DEPTH];
    int     seed;

    clk_gen u_clk_gen (
        .Clk   (Clk),
        .rst_n (rst_n)
    );

    sprite_layer_top u_sprite_layer_top (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_x       (in_x),
        .in_y       (in_y),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_color  (out_color),
        .out_opaque (out_opaque),
        .s0_x       (s0_x),
        .s0_y       (s0_y),
        .s0_pose    (s0_pose),
        .s1_x       (s1_x),
        .s1_y       (s1_y),
        .s1_pose    (s1_pose),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    // ------------------------------------------------------------------------
    // error handling and compares
    // ------------------------------------------------------------------------

    task automatic halt_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_color(input string name, input color_t exp, input color_t act);
        if (act !== exp) begin
            halt_run($sformatf("FAIL %s: expected %0h, actual %0h", name, exp, act));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            halt_run($sformatf("FAIL %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    // pose * 64 + row * 8 + col
    function automatic rom_addr_t image_addr(input pose_t pose, input int row, input int col);
        return rom_addr_t'(int'(pose) * `SPRITE_SIDE * `SPRITE_SIDE + row * `SPRITE_SIDE + col);
    endfunction

    // one sprite's color or 0 on a miss
    function automatic color_t sprite_color(input coord_t x, input coord_t y,
                                            input coord_t px, input coord_t py,
                                            input pose_t pose);
        int col;
        int row;
        col = int'(x) - int'(px) + `SPRITE_HALF;
        row = int'(y) - int'(py) + `SPRITE_HALF;
        if (col < 0 || col >= `SPRITE_SIDE || row < 0 || row >= `SPRITE_SIDE) begin
            return '0;
        end
        return image[image_addr(pose, row, col)];
    endfunction

    function automatic color_t model_color(input coord_t x, input coord_t y);
        color_t c0;
        color_t c1;
        c0 = sprite_color(x, y, s0_x, s0_y, s0_pose);
        c1 = sprite_color(x, y, s1_x, s1_y, s1_pose);
        // transparent sprite 0 falls through to sprite 1
        if (c0 != '0) begin
            return c0;
        end
        return c1;
    endfunction

    // ------------------------------------------------------------------------
    // bus tasks start and end just after a falling edge
    // ------------------------------------------------------------------------

    task automatic write_pixel(input rom_addr_t addr, input color_t data);
        int cycles;
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        cycles   = 0;
        do begin
            @(posedge Clk);
            cycles++;
        end while (!wr_ready && cycles < HS_LIMIT);
        if (!wr_ready) begin
            halt_run("loader write was never granted");
        end
        image[addr] = data;
        @(negedge Clk);
        wr_valid = 1'b0;
    endtask

    task automatic send_pixel(input coord_t x, input coord_t y);
        int cycles;
        in_valid = 1'b1;
        in_x     = x;
        in_y     = y;
        cycles   = 0;
        do begin
            @(posedge Clk);
            cycles++;
        end while (!in_ready && cycles < HS_LIMIT);
        if (!in_ready) begin
            halt_run("pixel input was never accepted");
        end
        @(negedge Clk);
        in_valid = 1'b0;
    endtask

    // returns right after the edge where out_valid was seen
    task automatic wait_out_valid();
        int cycles;
        cycles = 0;
        do begin
            @(posedge Clk);
            cycles++;
        end while (!out_valid && cycles < HS_LIMIT);
        if (!out_valid) begin
            halt_run("output pixel never became valid");
        end
    endtask

    task automatic render_expect(input string name, input coord_t x, input coord_t y,
                                 input color_t exp_color, input logic exp_opaque);
        color_t got_color;
        logic   got_opaque;
        send_pixel(x, y);
        wait_out_valid();
        got_color  = out_color;
        got_opaque = out_opaque;
        @(negedge Clk);
        compare_color(name, exp_color, got_color);
        compare_bit(name, exp_opaque, got_opaque);
    endtask

    task automatic render_pixel(input string name, input coord_t x, input coord_t y);
        color_t exp_color;
        exp_color = model_color(x, y);
        render_expect(name, x, y, exp_color, exp_color != '0);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------

    task automatic sprite0_corners();
        for (int i = 0; i < `ROM_DEPTH; i++) begin
            write_pixel(rom_addr_t'(i), color_t'($random(seed)));
        end
        render_pixel("corner_tl", s0_x - 10'd4, s0_y - 10'd4);
        render_pixel("corner_tr", s0_x + 10'd3, s0_y - 10'd4);
        render_pixel("corner_bl", s0_x - 10'd4, s0_y + 10'd3);
        render_pixel("corner_br", s0_x + 10'd3, s0_y + 10'd3);
        render_pixel("center", s0_x, s0_y);
    endtask

    task automatic outside_boxes();
        // first row or column past each edge
        render_expect("out_left", s0_x - 10'd5, s0_y, 4'h0, 1'b0);
        render_expect("out_right", s0_x + 10'd4, s0_y, 4'h0, 1'b0);
        render_expect("out_top", s0_x, s0_y - 10'd5, 4'h0, 1'b0);
        render_expect("out_bottom", s0_x, s0_y + 10'd4, 4'h0, 1'b0);
        render_expect("out_s1_right", s1_x + 10'd4, s1_y, 4'h0, 1'b0);
    endtask

    task automatic overlap_priority();
        // s1 box covers the lower right of s0
        s1_x = 10'd104;
        s1_y = 10'd62;
        // pixel (101, 60) is s0 row 4 col 5 and s1 row 2 col 1
        write_pixel(image_addr(s0_pose, 4, 5), 4'h9);
        write_pixel(image_addr(s1_pose, 2, 1), 4'h5);
        render_expect("overlap_front", 10'd101, 10'd60, 4'h9, 1'b1);
        render_pixel("overlap_a", 10'd102, 10'd61);
        render_pixel("overlap_b", 10'd100, 10'd63);
    endtask

    task automatic transparent_fallthrough();
        write_pixel(image_addr(s0_pose, 4, 5), 4'h0);
        render_expect("fall_to_s1", 10'd101, 10'd60, 4'h5, 1'b1);
        // (97, 57) misses s1
        write_pixel(image_addr(s0_pose, 1, 1), 4'h0);
        render_expect("fall_to_bg", 10'd97, 10'd57, 4'h0, 1'b0);
    endtask

    task automatic pose_switch();
        s1_x = 10'd300;
        s1_y = 10'd200;
        for (int p = 0; p < 4; p++) begin
            s1_pose = pose_t'(p);
            render_pixel("pose_center", s1_x, s1_y);
            render_pixel("pose_corner", s1_x - 10'd3, s1_y + 10'd3);
        end
        s1_pose = pose_move_right;
    endtask

    task automatic backpressure_and_loads();
        color_t exp_color;
        color_t held_color;
        logic   held_opaque;
        exp_color = model_color(s0_x, s0_y);
        out_ready = 1'b0;
        send_pixel(s0_x, s0_y);
        wait_out_valid();
        held_color  = out_color;
        held_opaque = out_opaque;
        compare_color("hold_first", exp_color, held_color);
        compare_bit("hold_first", exp_color != '0, held_opaque);
        // stalled result must not move
        repeat (6) begin
            @(posedge Clk);
            compare_bit("hold_valid", 1'b1, out_valid);
            compare_color("hold_color", held_color, out_color);
            compare_bit("hold_opaque", held_opaque, out_opaque);
            compare_bit("hold_in_ready", 1'b0, in_ready);
        end
        @(negedge Clk);
        out_ready = 1'b1;
        @(posedge Clk);
        compare_bit("hold_release", 1'b1, out_valid);
        @(negedge Clk);
        // output taken on that edge and the input side is open again
        compare_bit("release_out_valid", 1'b0, out_valid);
        compare_bit("release_in_ready", 1'b1, in_ready);
        // loader writes the attack block while pixels render
        fork
            begin
                render_pixel("busy_a", s0_x - 10'd1, s0_y);
                render_pixel("busy_b", s0_x + 10'd2, s0_y - 10'd3);
                render_pixel("busy_c", s0_x - 10'd4, s0_y + 10'd1);
                render_pixel("busy_d", s0_x + 10'd1, s0_y + 10'd2);
            end
            begin
                for (int i = 0; i < `SPRITE_SIDE; i++) begin
                    write_pixel(image_addr(pose_attack, 0, i), color_t'(i + 1));
                end
            end
        join
        // top row of s1 now reads the new data
        s1_pose = pose_attack;
        for (int i = 0; i < `SPRITE_SIDE; i++) begin
            render_pixel("new_data", s1_x - 10'd4 + coord_t'(i), s1_y - 10'd4);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        seed      = 32'h1a28;
        in_valid  = 1'b0;
        in_x      = '0;
        in_y      = '0;
        out_ready = 1'b1;
        s0_x      = 10'd100;
        s0_y      = 10'd60;
        s0_pose   = pose_stand;
        s1_x      = 10'd300;
        s1_y      = 10'd200;
        s1_pose   = pose_move_right;
        wr_valid  = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        wait (rst_n === 1'b1);
        @(posedge Clk);
        compare_bit("reset_in_ready", 1'b1, in_ready);
        compare_bit("reset_out_valid", 1'b0, out_valid);
        compare_bit("reset_wr_ready", 1'b0, wr_ready);
        @(negedge Clk);
        sprite0_corners();
        outside_boxes();
        overlap_priority();
        transparent_fallthrough();
        pose_switch();
        backpressure_and_loads();
        $display("Simulation passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge Clk);
        halt_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/sprite_pkg.sv
rtl/sprite_unit.sv
rtl/rom_arbiter.sv
rtl/sprite_rom.sv
rtl/pixel_compositor.sv
rtl/sprite_layer_top.sv
verification/clk_gen.sv
verification/sprite_sva.sv
verification/sprite_tb.sv

// File: run.sh
#!/bin/sh
# build and run the sprite layer testbench with Verilator
verilator --binary --timing --assert -Wno-fatal \
    --top-module sprite_tb -f src.f -o sim_sprite \
    && ./obj_dir/sim_sprite \
    || { echo "sprite layer run did not pass"; exit 1; }
